//--- design/alu_config_pkg.sv
// Widths, depths, buffer class and ALU opcode enums, slot word and configuration record types
package alu_config_pkg;

    // ------------------------------------------------------------
    // Widths and sizes
    // ------------------------------------------------------------
    localparam int DATA_W       = 32;
    localparam int ADDR_W       = 32;
    localparam int SHIFT_W      = 5;
    localparam int SLOT_COUNT   = 16;
    localparam int SLOT_W       = 4;
    localparam int NUM_OPERANDS = 4;
    localparam int MASK_W       = 4;

    // Both FIFOs share depth and threshold
    localparam int FIFO_DEPTH  = 32;
    localparam int PROG_THRESH = 16;

    // ------------------------------------------------------------
    // Enums
    // ------------------------------------------------------------
    typedef enum logic [2:0] {
        BUF_INVALID,
        BUF_CU_SETUP,
        BUF_ENGINE_SETUP,
        BUF_GRAPH_DATA,
        BUF_AUXILIARY
    } buffer_class_e;

    typedef enum logic [MASK_W-1:0] {
        ALU_NOP,
        ALU_ADD,
        ALU_SUB,
        ALU_MUL,
        ALU_ACC,
        ALU_DIV,
        ALU_GT,
        ALU_EQ,
        ALU_MAX,
        ALU_MIN
    } alu_op_e;

    // ------------------------------------------------------------
    // Records
    // ------------------------------------------------------------
    // One kept response word, already reduced to its slot
    typedef struct packed {
        logic [SLOT_W-1:0] slot;
        logic [DATA_W-1:0] data;
    } slot_word_t;

    typedef struct packed {
        alu_op_e                               alu_op;
        logic [NUM_OPERANDS-1:0][DATA_W-1:0]   operands;
        logic [MASK_W-1:0]                     alu_mask;
        logic [MASK_W-1:0]                     field_mask;
    } alu_config_t;

endpackage

//--- design/fifo_read_if.sv
// Read side of a synchronous FIFO with modports for the FIFO and its reader
`timescale 1ns/1ps

interface fifo_read_if #(
    parameter int WIDTH = 8
);

    logic             rd_en;
    logic             valid;
    logic [WIDTH-1:0] data;
    logic             empty;
    logic             prog_full;

    // FIFO side returns data and flags
    modport fifo (
        input  rd_en,
        output valid,
        output data,
        output empty,
        output prog_full
    );

    modport reader (
        output rd_en,
        input  valid,
        input  data,
        input  empty,
        input  prog_full
    );

endinterface

//--- design/sync_fifo.sv
// Synchronous FIFO with registered read data, read valid, full, empty and programmable full
`timescale 1ns/1ps

module sync_fifo #(
    parameter int WIDTH  = 8,
    parameter int DEPTH  = 32,
    parameter int THRESH = 16
) (
    input  logic             ap_clk,
    input  logic             areset_csr_index_generator,
    input  logic [WIDTH-1:0] din,
    input  logic             wr_en,
    output logic             full,
    fifo_read_if.fifo        rd
);

    logic [WIDTH-1:0]           mem [DEPTH];
    logic [$clog2(DEPTH)-1:0]   wr_ptr;
    logic [$clog2(DEPTH)-1:0]   rd_ptr;
    logic [$clog2(DEPTH):0]     count;
    logic                       push;
    logic                       pop;

    // ------------------------------------------------------------
    // Flags
    // ------------------------------------------------------------
    assign push         = wr_en && !full;
    assign pop          = rd.rd_en && !rd.empty;
    assign full         = (count == ($clog2(DEPTH)+1)'(DEPTH));
    assign rd.empty     = (count == '0);
    assign rd.prog_full = (count >= ($clog2(DEPTH)+1)'(THRESH));

    // ------------------------------------------------------------
    // Pointers and fill level
    // ------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_csr_index_generator) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            rd.valid <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // Popped word shows up one cycle later
            rd.valid <= pop;
        end
    end

    // Storage and read register
    always_ff @(posedge ap_clk) begin
        if (push) begin
            mem[wr_ptr] <= din;
        end
        if (pop) begin
            rd.data <= mem[rd_ptr];
        end
    end

    // ------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------
    // Fill level agrees with the pointer distance
    count_matches_ptrs: assert property (
        @(posedge ap_clk) disable iff (areset_csr_index_generator)
        count[$clog2(DEPTH)-1:0] == wr_ptr - rd_ptr
    ) else $error("fill count out of step with the pointers");

    count_in_range: assert property (
        @(posedge ap_clk) disable iff (areset_csr_index_generator)
        count <= ($clog2(DEPTH)+1)'(DEPTH)
    ) else $error("fill count beyond depth");

endmodule

//--- design/resp_filter.sv
// Response input register, sequence number computation and class/window filter
`timescale 1ns/1ps

module resp_filter
    import alu_config_pkg::*;
#(
    parameter int SEQ_BASE = 0
) (
    input  logic                ap_clk,
    input  logic                areset_csr_index_generator,
    input  logic                resp_valid,
    input  buffer_class_e       resp_buffer,
    input  logic [ADDR_W-1:0]   resp_offset,
    input  logic [SHIFT_W-1:0]  resp_shift,
    input  logic [DATA_W-1:0]   resp_data,
    output slot_word_t          word,
    output logic                word_wr_en
);

    logic                valid_q;
    buffer_class_e       buffer_q;
    logic [ADDR_W-1:0]   offset_q;
    logic [SHIFT_W-1:0]  shift_q;
    logic [DATA_W-1:0]   data_q;
    logic [ADDR_W-1:0]   seq_rel;
    logic                class_ok;
    logic                window_ok;

    // ------------------------------------------------------------
    // Input register
    // ------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_csr_index_generator) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= resp_valid;
        end
    end

    always_ff @(posedge ap_clk) begin
        buffer_q <= resp_buffer;
        offset_q <= resp_offset;
        shift_q  <= resp_shift;
        data_q   <= resp_data;
    end

    // ------------------------------------------------------------
    // Filter
    // ------------------------------------------------------------
    // Relative sequence wraps below the base, so one compare covers both bounds
    assign seq_rel   = (offset_q >> shift_q) - ADDR_W'(SEQ_BASE);
    assign window_ok = (seq_rel < ADDR_W'(SLOT_COUNT));
    assign class_ok  = (buffer_q == BUF_CU_SETUP) || (buffer_q == BUF_ENGINE_SETUP);

    assign word_wr_en = valid_q && class_ok && window_ok;
    assign word.slot  = seq_rel[SLOT_W-1:0];
    assign word.data  = data_q;

endmodule

//--- design/config_assembler.sv
// Slot collection, completion detection, input pop gating and configuration record register
`timescale 1ns/1ps

module config_assembler
    import alu_config_pkg::*;
(
    input  logic          ap_clk,
    input  logic          areset_csr_index_generator,
    input  logic          resp_rd_en,
    fifo_read_if.reader   words,
    input  logic          cfg_prog_full,
    output alu_config_t   cfg_record,
    output logic          cfg_wr_en
);

    slot_word_t              word_in;
    alu_config_t             fields_q;
    logic [SLOT_COUNT-1:0]   present;
    logic [SLOT_COUNT-1:0]   slot_hit;
    logic                    complete;

    assign word_in  = words.data;
    assign slot_hit = words.valid ? (SLOT_COUNT'(1) << word_in.slot) : '0;
    assign complete = &present;

    // ------------------------------------------------------------
    // Pop gating
    // ------------------------------------------------------------
    // Hold off while a record waits to be pushed or the output side is filling up
    assign words.rd_en = resp_rd_en && !words.empty && !complete && !cfg_prog_full;

    // ------------------------------------------------------------
    // Presence vector and write strobe
    // ------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_csr_index_generator) begin
            present   <= '0;
            cfg_wr_en <= 1'b0;
        end else begin
            cfg_wr_en <= complete;
            // A word still in flight at the clear starts the next record
            if (complete) begin
                present <= slot_hit;
            end else begin
                present <= present | slot_hit;
            end
        end
    end

    // ------------------------------------------------------------
    // Field capture
    // ------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (words.valid) begin
            case (word_in.slot)
                4'd0:    fields_q.alu_op      <= alu_op_e'(word_in.data[MASK_W-1:0]);
                4'd1:    fields_q.operands[0] <= word_in.data;
                4'd2:    fields_q.operands[1] <= word_in.data;
                4'd3:    fields_q.operands[2] <= word_in.data;
                4'd4:    fields_q.operands[3] <= word_in.data;
                4'd5:    fields_q.alu_mask    <= word_in.data[MASK_W-1:0];
                4'd6:    fields_q.field_mask  <= word_in.data[MASK_W-1:0];
                // Slots 7 to 15 only mark presence
                default: fields_q <= fields_q;
            endcase
        end
    end

    // Snapshot taken on the same edge as the strobe, before any new word lands
    always_ff @(posedge ap_clk) begin
        if (complete) begin
            cfg_record <= fields_q;
        end
    end

    // ------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------
    // Input FIFO returns nothing for a cycle in which the record was complete
    no_pop_when_complete: assert property (
        @(posedge ap_clk) disable iff (areset_csr_index_generator)
        complete |=> !words.valid
    ) else $error("input word popped while record complete");

endmodule

//--- design/alu_config_collector.sv
// ALU configuration collector top level: filter, input FIFO, assembler and output FIFO
`timescale 1ns/1ps

module alu_config_collector
    import alu_config_pkg::*;
#(
    parameter int SEQ_BASE = 0
) (
    input  logic                                ap_clk,
    input  logic                                areset_csr_index_generator,
    input  logic                                resp_valid,
    input  buffer_class_e                       resp_buffer,
    input  logic [ADDR_W-1:0]                   resp_offset,
    input  logic [SHIFT_W-1:0]                  resp_shift,
    input  logic [DATA_W-1:0]                   resp_data,
    input  logic                                resp_rd_en,
    output logic                                resp_full,
    input  logic                                cfg_rd_en,
    output logic                                cfg_valid,
    output logic                                cfg_empty,
    output alu_op_e                             cfg_alu_op,
    output logic [NUM_OPERANDS-1:0][DATA_W-1:0] cfg_operands,
    output logic [MASK_W-1:0]                   cfg_alu_mask,
    output logic [MASK_W-1:0]                   cfg_field_mask
);

    slot_word_t    word;
    logic          word_wr_en;
    alu_config_t   cfg_record;
    logic          cfg_wr_en;
    alu_config_t   cfg_out;

    fifo_read_if #(.WIDTH($bits(slot_word_t)))  word_rd ();
    fifo_read_if #(.WIDTH($bits(alu_config_t))) cfg_rd ();

    // ------------------------------------------------------------
    // Input path
    // ------------------------------------------------------------
    resp_filter #(
        .SEQ_BASE(SEQ_BASE)
    ) u_filter (
        .ap_clk                     (ap_clk),
        .areset_csr_index_generator (areset_csr_index_generator),
        .resp_valid                 (resp_valid),
        .resp_buffer                (resp_buffer),
        .resp_offset                (resp_offset),
        .resp_shift                 (resp_shift),
        .resp_data                  (resp_data),
        .word                       (word),
        .word_wr_en                 (word_wr_en)
    );

    sync_fifo #(
        .WIDTH  ($bits(slot_word_t)),
        .DEPTH  (FIFO_DEPTH),
        .THRESH (PROG_THRESH)
    ) u_word_fifo (
        .ap_clk                     (ap_clk),
        .areset_csr_index_generator (areset_csr_index_generator),
        .din                        (word),
        .wr_en                      (word_wr_en),
        .full                       (resp_full),
        .rd                         (word_rd.fifo)
    );

    config_assembler u_assembler (
        .ap_clk                     (ap_clk),
        .areset_csr_index_generator (areset_csr_index_generator),
        .resp_rd_en                 (resp_rd_en),
        .words                      (word_rd.reader),
        .cfg_prog_full              (cfg_rd.prog_full),
        .cfg_record                 (cfg_record),
        .cfg_wr_en                  (cfg_wr_en)
    );

    // ------------------------------------------------------------
    // Output path
    // ------------------------------------------------------------
    // Assembler stalls on prog_full well before this one fills
    sync_fifo #(
        .WIDTH  ($bits(alu_config_t)),
        .DEPTH  (FIFO_DEPTH),
        .THRESH (PROG_THRESH)
    ) u_cfg_fifo (
        .ap_clk                     (ap_clk),
        .areset_csr_index_generator (areset_csr_index_generator),
        .din                        (cfg_record),
        .wr_en                      (cfg_wr_en),
        .full                       (),
        .rd                         (cfg_rd.fifo)
    );

    assign cfg_rd.rd_en   = cfg_rd_en;
    assign cfg_valid      = cfg_rd.valid;
    assign cfg_empty      = cfg_rd.empty;
    assign cfg_out        = cfg_rd.data;
    assign cfg_alu_op     = cfg_out.alu_op;
    assign cfg_operands   = cfg_out.operands;
    assign cfg_alu_mask   = cfg_out.alu_mask;
    assign cfg_field_mask = cfg_out.field_mask;

endmodule

//--- sim/tb_alu_config_collector.sv
// Testbench for the ALU configuration collector with reference model and output checks
`timescale 1ns/1ps

module tb_alu_config_collector
    import alu_config_pkg::*;
();

    localparam int SEQ_BASE   = 32;
    localparam int WAIT_LIMIT = 400;

    logic                                ap_clk;
    logic                                areset_csr_index_generator;
    logic                                resp_valid;
    buffer_class_e                       resp_buffer;
    logic [ADDR_W-1:0]                   resp_offset;
    logic [SHIFT_W-1:0]                  resp_shift;
    logic [DATA_W-1:0]                   resp_data;
    logic                                resp_rd_en;
    logic                                resp_full;
    logic                                cfg_rd_en;
    logic                                cfg_valid;
    logic                                cfg_empty;
    alu_op_e                             cfg_alu_op;
    logic [NUM_OPERANDS-1:0][DATA_W-1:0] cfg_operands;
    logic [MASK_W-1:0]                   cfg_alu_mask;
    logic [MASK_W-1:0]                   cfg_field_mask;

    alu_config_t           cfg_now;
    alu_config_t           exp_cfg [16];
    int                    exp_wr;
    int                    exp_rd;
    alu_config_t           model_cfg;
    logic [SLOT_COUNT-1:0] model_present;
    logic                  hold_output;
    string                 test_name;
    int                    seed;
    int                    order [SLOT_COUNT];

    alu_config_collector #(
        .SEQ_BASE(SEQ_BASE)
    ) uut (
        .ap_clk                     (ap_clk),
        .areset_csr_index_generator (areset_csr_index_generator),
        .resp_valid                 (resp_valid),
        .resp_buffer                (resp_buffer),
        .resp_offset                (resp_offset),
        .resp_shift                 (resp_shift),
        .resp_data                  (resp_data),
        .resp_rd_en                 (resp_rd_en),
        .resp_full                  (resp_full),
        .cfg_rd_en                  (cfg_rd_en),
        .cfg_valid                  (cfg_valid),
        .cfg_empty                  (cfg_empty),
        .cfg_alu_op                 (cfg_alu_op),
        .cfg_operands               (cfg_operands),
        .cfg_alu_mask               (cfg_alu_mask),
        .cfg_field_mask             (cfg_field_mask)
    );

    initial begin
        ap_clk = 1'b0;
        forever #2 ap_clk = ~ap_clk;
    end

    assign cfg_now = {cfg_alu_op, cfg_operands, cfg_alu_mask, cfg_field_mask};

    // Read pointer into the expected records
    always @(posedge ap_clk) begin
        if (areset_csr_index_generator) begin
            exp_rd <= 0;
        end else if (cfg_valid) begin
            exp_rd <= exp_rd + 1;
        end
    end

    task automatic stop_with_failure();
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    // ------------------------------------------------------------
    // Output checks, sampled mid-cycle
    // ------------------------------------------------------------
    output_expected: assert property (
        @(negedge ap_clk) disable iff (areset_csr_index_generator)
        cfg_valid |-> (exp_rd < exp_wr) && !hold_output
    ) else begin
        $display("Unexpected configuration output during %s", test_name);
        stop_with_failure();
    end

    record_matches: assert property (
        @(negedge ap_clk) disable iff (areset_csr_index_generator)
        (cfg_valid && exp_rd < exp_wr) |-> (cfg_now == exp_cfg[exp_rd])
    ) else begin
        $display("MISMATCH %s expected %h actual %h", test_name, exp_cfg[exp_rd], cfg_now);
        stop_with_failure();
    end

    // ------------------------------------------------------------
    // Reference model and stimulus
    // ------------------------------------------------------------
    task automatic model_word(input buffer_class_e buf_class, input logic [ADDR_W-1:0] offset,
                              input logic [SHIFT_W-1:0] shift, input logic [DATA_W-1:0] data);
        logic [ADDR_W-1:0] seq;
        int                slot;
        seq = offset >> shift;
        if ((buf_class == BUF_CU_SETUP || buf_class == BUF_ENGINE_SETUP)
                && seq >= ADDR_W'(SEQ_BASE) && seq < ADDR_W'(SEQ_BASE + SLOT_COUNT)) begin
            slot = int'(seq - ADDR_W'(SEQ_BASE));
            case (slot)
                0:          model_cfg.alu_op = alu_op_e'(data[MASK_W-1:0]);
                1, 2, 3, 4: model_cfg.operands[slot - 1] = data;
                5:          model_cfg.alu_mask = data[MASK_W-1:0];
                6:          model_cfg.field_mask = data[MASK_W-1:0];
                default:    ;
            endcase
            model_present[slot] = 1'b1;
            // Full slot set closes the record
            if (&model_present) begin
                exp_cfg[exp_wr] = model_cfg;
                exp_wr++;
                model_present = '0;
            end
        end
    endtask

    task automatic send_word(input buffer_class_e buf_class, input logic [ADDR_W-1:0] offset,
                             input logic [SHIFT_W-1:0] shift, input logic [DATA_W-1:0] data);
        int waited;
        waited = 0;
        @(posedge ap_clk);
        while (resp_full && waited < WAIT_LIMIT) begin
            resp_valid <= 1'b0;
            @(posedge ap_clk);
            waited++;
        end
        if (resp_full) begin
            $display("Timeout waiting for the input FIFO to leave full in %s", test_name);
            stop_with_failure();
        end else begin
            resp_valid  <= 1'b1;
            resp_buffer <= buf_class;
            resp_offset <= offset;
            resp_shift  <= shift;
            resp_data   <= data;
            model_word(buf_class, offset, shift, data);
        end
    endtask

    task automatic end_burst();
        @(posedge ap_clk);
        resp_valid <= 1'b0;
    endtask

    task automatic send_ordered_config();
        for (int s = 0; s < SLOT_COUNT; s++) begin
            send_word(BUF_CU_SETUP, ADDR_W'(SEQ_BASE + s), '0, $random(seed));
        end
        end_burst();
    endtask

    // Shuffled slots with offsets scaled by 4 and shift 2
    task automatic send_shuffled_config();
        int j;
        int tmp;
        int found;
        int rep [2];
        for (int i = 0; i < SLOT_COUNT; i++) begin
            order[i] = i;
        end
        for (int i = SLOT_COUNT - 1; i > 0; i--) begin
            j = int'({$random(seed)} % (i + 1));
            tmp = order[i];
            order[i] = order[j];
            order[j] = tmp;
        end
        // First two field slots ahead of the last one get a second value
        found = 0;
        for (int i = 0; i < SLOT_COUNT - 1; i++) begin
            if (order[i] < 7 && found < 2) begin
                rep[found] = order[i];
                found++;
            end
        end
        for (int i = 0; i < SLOT_COUNT + 2; i++) begin
            if (i < SLOT_COUNT - 1) begin
                j = order[i];
            end else if (i < SLOT_COUNT + 1) begin
                j = rep[i - (SLOT_COUNT - 1)];
            end else begin
                j = order[SLOT_COUNT - 1];
            end
            send_word(BUF_ENGINE_SETUP, ADDR_W'((SEQ_BASE + j) * 4 + ($random(seed) & 3)),
                      5'd2, $random(seed));
        end
        end_burst();
    endtask

    task automatic wait_drained(input int count, input string what);
        int waited;
        waited = 0;
        while (exp_rd != exp_wr && waited < WAIT_LIMIT) begin
            @(posedge ap_clk);
            waited++;
        end
        if (exp_rd != exp_wr || exp_wr != count) begin
            $display("Timeout or wrong count waiting for %s in %s", what, test_name);
            stop_with_failure();
        end
    endtask

    // ------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------
    initial begin
        areset_csr_index_generator = 1'b1;
        resp_valid    = 1'b0;
        resp_buffer   = BUF_INVALID;
        resp_offset   = '0;
        resp_shift    = '0;
        resp_data     = '0;
        resp_rd_en    = 1'b1;
        cfg_rd_en     = 1'b1;
        hold_output   = 1'b0;
        exp_wr        = 0;
        model_cfg     = '0;
        model_present = '0;
        seed          = 86419;
        test_name     = "reset";
        repeat (2) @(posedge ap_clk);
        areset_csr_index_generator <= 1'b0;
        @(posedge ap_clk);
        assert (!cfg_valid && cfg_empty && !resp_full) else begin
            $display("Output flags or input full flag wrong after reset");
            stop_with_failure();
        end

        test_name = "ordered";
        send_ordered_config();
        wait_drained(1, "ordered configuration");

        test_name = "shuffled";
        send_shuffled_config();
        wait_drained(2, "shuffled configuration");

        // Slots 0 to 9 kept, the rest of the burst filtered out
        test_name = "filter";
        hold_output <= 1'b1;
        for (int s = 0; s < 10; s++) begin
            send_word(BUF_CU_SETUP, ADDR_W'(SEQ_BASE + s), '0, $random(seed));
        end
        for (int s = 10; s < SLOT_COUNT; s++) begin
            send_word(BUF_GRAPH_DATA, ADDR_W'(SEQ_BASE + s), '0, $random(seed));
        end
        send_word(BUF_CU_SETUP, ADDR_W'(SEQ_BASE - 1), '0, $random(seed));
        send_word(BUF_ENGINE_SETUP, ADDR_W'(SEQ_BASE + SLOT_COUNT), '0, $random(seed));
        send_word(BUF_CU_SETUP, ADDR_W'((SEQ_BASE + SLOT_COUNT) * 2), 5'd1, $random(seed));
        end_burst();
        repeat (40) @(posedge ap_clk);
        hold_output <= 1'b0;
        for (int s = 10; s < SLOT_COUNT; s++) begin
            send_word(BUF_ENGINE_SETUP, ADDR_W'(SEQ_BASE + s), '0, $random(seed));
        end
        end_burst();
        wait_drained(3, "completed filtered configuration");

        test_name = "output_hold";
        cfg_rd_en   <= 1'b0;
        hold_output <= 1'b1;
        repeat (3) send_ordered_config();
        repeat (60) @(posedge ap_clk);
        cfg_rd_en   <= 1'b1;
        hold_output <= 1'b0;
        wait_drained(6, "three held configurations");
        assert (cfg_empty) else begin
            $display("Output FIFO not empty after all configurations were read");
            stop_with_failure();
        end

        test_name = "input_hold";
        resp_rd_en  <= 1'b0;
        hold_output <= 1'b1;
        send_ordered_config();
        repeat (40) @(posedge ap_clk);
        resp_rd_en  <= 1'b1;
        hold_output <= 1'b0;
        wait_drained(7, "released configuration");

        if (exp_rd == exp_wr && exp_wr == 7) begin
            $display("PASS: all tests");
            $finish;
        end else begin
            $display("Configuration count wrong at the end of the run");
            stop_with_failure();
        end
    end

endmodule

//--- verilog.f
design/alu_config_pkg.sv
design/fifo_read_if.sv
design/sync_fifo.sv
design/resp_filter.sv
design/config_assembler.sv
design/alu_config_collector.sv
sim/tb_alu_config_collector.sv

//--- run_sim.sh
#!/bin/sh
# Build with Verilator, run the testbench and decide from the log
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert --top-module tb_alu_config_collector \
    -f verilog.f -o Vtb_alu_config_collector
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vtb_alu_config_collector > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
fi

if grep -q "^PASS: all tests$" "$LOG"; then
    exit 0
fi
echo "Simulation did not pass, see $LOG"
exit 1
